// ==== verilog/uart_regs_pkg.sv ====
package uart_regs_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;
  // Divisor latch, DLM:DLL
  localparam int DL_W   = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  // Address 0 and 1 are shared, DLAB selects the divisor latch
  localparam logic [ADDR_W-1:0] RBR_ADR = 3'd0;
  localparam logic [ADDR_W-1:0] THR_ADR = 3'd0;
  localparam logic [ADDR_W-1:0] DLL_ADR = 3'd0;
  localparam logic [ADDR_W-1:0] IER_ADR = 3'd1;
  localparam logic [ADDR_W-1:0] DLM_ADR = 3'd1;
  // Ident register, reads as zero
  localparam logic [ADDR_W-1:0] IIR_ADR = 3'd2;
  localparam logic [ADDR_W-1:0] LCR_ADR = 3'd3;
  localparam logic [ADDR_W-1:0] MCR_ADR = 3'd4;
  localparam logic [ADDR_W-1:0] LSR_ADR = 3'd5;
  localparam logic [ADDR_W-1:0] MSR_ADR = 3'd6;
  localparam logic [ADDR_W-1:0] SCR_ADR = 3'd7;

  ////////////////////////////////////////////////////////////////////////////
  // Register layouts, msb first
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] rsvd;
    logic       edssi;
    logic       elsi;
    logic       etbei;
    logic       erbi;
  } ier_t;

  typedef struct packed {
    logic       dlab;
    logic       brk;
    logic       stick_par;
    logic       eps;
    logic       pen;
    logic       stb;
    logic [1:0] wls;
  } lcr_t;

  typedef struct packed {
    logic [2:0] rsvd;
    logic       loop;
    logic       out2;
    logic       out1;
    logic       rts;
    logic       dtr;
  } mcr_t;

  typedef struct packed {
    logic rx_fifo_err;
    logic temt;
    logic thre;
    logic bi;
    logic fe;
    logic pe;
    logic oe;
    logic dr;
  } lsr_t;

  typedef struct packed {
    logic dcd;
    logic ri;
    logic dsr;
    logic cts;
    logic ddcd;
    logic teri;
    logic ddsr;
    logic dcts;
  } msr_t;

  // Both transmitter empty flags set out of reset
  localparam logic [DATA_W-1:0] LSR_RESET = 8'h60;

endpackage

// ==== verilog/uart_baud_gen.sv ====
`timescale 1ns/10ps

module uart_baud_gen (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [uart_regs_pkg::DL_W-1:0] dl,
  input  logic                           dl_load,
  output logic                           baudout_o
);

  logic [uart_regs_pkg::DL_W-1:0] cnt;

  // Down counter, period of dl cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt <= '0;
    else if (dl_load || cnt == '0)
      cnt <= dl - 1'b1;
    else
      cnt <= cnt - 1'b1;
  end

  // 16x clock enable, held off for a zero divisor
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      baudout_o <= 1'b0;
    else
      baudout_o <= (|dl) & (cnt == '0);
  end

endmodule

// ==== verilog/uart_line_status.sv ====
`timescale 1ns/10ps

module uart_line_status (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rx_empty_i,
  input  logic                rx_pe_i,
  input  logic                rx_fe_i,
  input  logic                rx_bi_i,
  input  logic                overrun_error_i,
  input  logic                tx_empty_i,
  input  logic                tx_sr_empty_i,
  input  logic                read_lsr,
  output uart_regs_pkg::lsr_t lsr
);

  // Previous error levels, for edge detect
  logic d_oe;
  logic d_pe;
  logic d_fe;
  logic d_bi;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      d_oe <= 1'b0;
      d_pe <= 1'b0;
      d_fe <= 1'b0;
      d_bi <= 1'b0;
    end
    else
    begin
      d_oe <= overrun_error_i;
      d_pe <= rx_pe_i;
      d_fe <= rx_fe_i;
      d_bi <= rx_bi_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      lsr <= uart_regs_pkg::lsr_t'(uart_regs_pkg::LSR_RESET);
    else
    begin
      lsr.rx_fifo_err <= 1'b0;
      // Level status, plain one cycle delay
      lsr.dr   <= ~rx_empty_i;
      lsr.thre <= tx_empty_i;
      lsr.temt <= tx_empty_i & tx_sr_empty_i;
      // Sticky errors, a fresh edge beats the clearing read
      lsr.oe <= (overrun_error_i & ~d_oe) | (lsr.oe & ~read_lsr);
      lsr.pe <= (rx_pe_i & ~d_pe) | (lsr.pe & ~read_lsr);
      lsr.fe <= (rx_fe_i & ~d_fe) | (lsr.fe & ~read_lsr);
      lsr.bi <= (rx_bi_i & ~d_bi) | (lsr.bi & ~read_lsr);
    end
  end

endmodule

// ==== verilog/uart_modem_status.sv ====
`timescale 1ns/10ps

module uart_modem_status (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cts_ni,
  input  logic                dsr_ni,
  input  logic                dcd_ni,
  input  logic                ri_ni,
  input  uart_regs_pkg::mcr_t mcr,
  input  logic                read_msr,
  output uart_regs_pkg::msr_t msr
);

  // Pin history, inactive level out of reset
  logic d_cts_ni;
  logic d_dsr_ni;
  logic d_dcd_ni;
  logic d_ri_ni;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      d_cts_ni <= 1'b1;
      d_dsr_ni <= 1'b1;
      d_dcd_ni <= 1'b1;
      d_ri_ni  <= 1'b1;
    end
    else
    begin
      d_cts_ni <= cts_ni;
      d_dsr_ni <= dsr_ni;
      d_dcd_ni <= dcd_ni;
      d_ri_ni  <= ri_ni;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      msr <= '0;
    else
    begin
      // Loopback feeds the MCR outputs back in
      msr.dcd <= mcr.loop ? mcr.out2 : ~dcd_ni;
      msr.ri  <= mcr.loop ? mcr.out1 : ~ri_ni;
      msr.dsr <= mcr.loop ? mcr.dtr  : ~dsr_ni;
      msr.cts <= mcr.loop ? mcr.rts  : ~cts_ni;
      // Any toggle
      msr.ddcd <= (dcd_ni ^ d_dcd_ni) | (msr.ddcd & ~read_msr);
      msr.ddsr <= (dsr_ni ^ d_dsr_ni) | (msr.ddsr & ~read_msr);
      msr.dcts <= (cts_ni ^ d_cts_ni) | (msr.dcts & ~read_msr);
      // Trailing edge of ring, pin going high
      msr.teri <= (ri_ni & ~d_ri_ni) | (msr.teri & ~read_msr);
    end
  end

endmodule

// ==== verilog/uart_csr_file.sv ====
`timescale 1ns/10ps

module uart_csr_file #(
  parameter logic [uart_regs_pkg::DL_W-1:0] DL_RESET_VALUE = 16'h0044
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [uart_regs_pkg::ADDR_W-1:0]  adr_i,
  input  logic [uart_regs_pkg::DATA_W-1:0]  d_i,
  input  logic                              re_i,
  input  logic                              we_i,
  input  logic [uart_regs_pkg::DATA_W-1:0]  rx_data_i,
  output logic [uart_regs_pkg::DATA_W-1:0]  q_o,
  output logic                              tx_push_o,
  output logic                              rx_pop_o,
  input  uart_regs_pkg::lsr_t               lsr,
  input  uart_regs_pkg::msr_t               msr,
  output uart_regs_pkg::mcr_t               mcr,
  output logic                              read_lsr,
  output logic                              read_msr,
  output logic [uart_regs_pkg::DL_W-1:0]    dl,
  output logic                              dl_load,
  output logic                              rts_no,
  output logic                              dtr_no,
  output logic                              out1_no,
  output logic                              out2_no,
  output logic                              irq_o
);

  uart_regs_pkg::ier_t                ier;
  uart_regs_pkg::lcr_t                lcr;
  logic [uart_regs_pkg::DATA_W-1:0]   scr;
  logic [uart_regs_pkg::DATA_W-1:0]   dll;
  logic [uart_regs_pkg::DATA_W-1:0]   dlm;
  logic                               wr_ier;
  logic                               wr_dll;
  logic                               wr_dlm;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // DLAB steers address 0 and 1 away from THR/RBR and IER
  assign wr_ier = we_i & (adr_i == uart_regs_pkg::IER_ADR) & ~lcr.dlab;
  assign wr_dll = we_i & (adr_i == uart_regs_pkg::DLL_ADR) & lcr.dlab;
  assign wr_dlm = we_i & (adr_i == uart_regs_pkg::DLM_ADR) & lcr.dlab;

  // FIFO strobes towards the transmitter and receiver
  assign tx_push_o = we_i & (adr_i == uart_regs_pkg::THR_ADR) & ~lcr.dlab;
  assign rx_pop_o  = re_i & (adr_i == uart_regs_pkg::RBR_ADR) & ~lcr.dlab;

  // Clear-on-read triggers for the status blocks
  assign read_lsr = re_i & (adr_i == uart_regs_pkg::LSR_ADR);
  assign read_msr = re_i & (adr_i == uart_regs_pkg::MSR_ADR);

  ////////////////////////////////////////////////////////////////////////////
  // Writeable registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ier <= '0;
      lcr <= '0;
      mcr <= '0;
      scr <= '0;
      dll <= DL_RESET_VALUE[uart_regs_pkg::DATA_W-1:0];
      dlm <= DL_RESET_VALUE[uart_regs_pkg::DL_W-1:uart_regs_pkg::DATA_W];
    end
    else
    begin
      // Upper nibble of IER is reserved
      if (wr_ier)
        ier <= uart_regs_pkg::ier_t'({4'h0, d_i[3:0]});
      if (we_i && adr_i == uart_regs_pkg::LCR_ADR)
        lcr <= uart_regs_pkg::lcr_t'(d_i);
      // Upper three bits of MCR are reserved
      if (we_i && adr_i == uart_regs_pkg::MCR_ADR)
        mcr <= uart_regs_pkg::mcr_t'({3'h0, d_i[4:0]});
      if (we_i && adr_i == uart_regs_pkg::SCR_ADR)
        scr <= d_i;
      if (wr_dll)
        dll <= d_i;
      if (wr_dlm)
        dlm <= d_i;
    end
  end

  assign dl = {dlm, dll};

  // Baud counter reload, one cycle behind the latch update
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dl_load <= 1'b0;
    else
      dl_load <= wr_dll | wr_dlm;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Sampled every cycle, re_i only matters for side effects
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      q_o <= '0;
    else
    begin
      case (adr_i)
        uart_regs_pkg::RBR_ADR: q_o <= lcr.dlab ? dll : rx_data_i;
        uart_regs_pkg::IER_ADR: q_o <= lcr.dlab ? dlm : ier;
        // No ident logic
        uart_regs_pkg::IIR_ADR: q_o <= '0;
        uart_regs_pkg::LCR_ADR: q_o <= lcr;
        uart_regs_pkg::MCR_ADR: q_o <= mcr;
        uart_regs_pkg::LSR_ADR: q_o <= lsr;
        uart_regs_pkg::MSR_ADR: q_o <= msr;
        uart_regs_pkg::SCR_ADR: q_o <= scr;
        default:                q_o <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Modem controls and interrupt
  ////////////////////////////////////////////////////////////////////////////

  // Pins are active low
  assign rts_no  = ~mcr.rts;
  assign dtr_no  = ~mcr.dtr;
  assign out1_no = ~mcr.out1;
  assign out2_no = ~mcr.out2;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      irq_o <= 1'b0;
    else
      irq_o <= (ier.edssi & (msr.ddcd | msr.teri | msr.ddsr | msr.dcts)) |
               (ier.elsi  & (lsr.oe | lsr.pe | lsr.fe | lsr.bi)) |
               (ier.etbei & lsr.thre) |
               // Received data, no trigger level without FIFO control
               (ier.erbi  & lsr.dr);
  end

endmodule

// ==== verilog/uart_regs_top.sv ====
`timescale 1ns/10ps

module uart_regs_top #(
  parameter logic [uart_regs_pkg::DL_W-1:0] DL_RESET_VALUE = 16'h0044
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Register port
  input  logic [uart_regs_pkg::ADDR_W-1:0] adr_i,
  input  logic [uart_regs_pkg::DATA_W-1:0] d_i,
  input  logic                             re_i,
  input  logic                             we_i,
  output logic [uart_regs_pkg::DATA_W-1:0] q_o,
  // Receiver and transmitter side
  input  logic [uart_regs_pkg::DATA_W-1:0] rx_data_i,
  input  logic                             rx_empty_i,
  input  logic                             rx_pe_i,
  input  logic                             rx_fe_i,
  input  logic                             rx_bi_i,
  input  logic                             overrun_error_i,
  input  logic                             tx_empty_i,
  input  logic                             tx_sr_empty_i,
  output logic                             tx_push_o,
  output logic                             rx_pop_o,
  // Modem pins, active low
  input  logic                             cts_ni,
  input  logic                             dsr_ni,
  input  logic                             dcd_ni,
  input  logic                             ri_ni,
  output logic                             rts_no,
  output logic                             dtr_no,
  output logic                             out1_no,
  output logic                             out2_no,
  output logic                             irq_o,
  output logic                             baudout_o
);

  uart_regs_pkg::lsr_t            lsr;
  uart_regs_pkg::msr_t            msr;
  uart_regs_pkg::mcr_t            mcr;
  logic                           read_lsr;
  logic                           read_msr;
  logic [uart_regs_pkg::DL_W-1:0] dl;
  logic                           dl_load;

  ////////////////////////////////////////////////////////////////////////////
  // Register file, status blocks, baud generator
  ////////////////////////////////////////////////////////////////////////////

  uart_csr_file #(
    .DL_RESET_VALUE (DL_RESET_VALUE)
  ) u_csr_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .adr_i     (adr_i),
    .d_i       (d_i),
    .re_i      (re_i),
    .we_i      (we_i),
    .rx_data_i (rx_data_i),
    .q_o       (q_o),
    .tx_push_o (tx_push_o),
    .rx_pop_o  (rx_pop_o),
    .lsr       (lsr),
    .msr       (msr),
    .mcr       (mcr),
    .read_lsr  (read_lsr),
    .read_msr  (read_msr),
    .dl        (dl),
    .dl_load   (dl_load),
    .rts_no    (rts_no),
    .dtr_no    (dtr_no),
    .out1_no   (out1_no),
    .out2_no   (out2_no),
    .irq_o     (irq_o)
  );

  uart_line_status u_line_status (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rx_empty_i      (rx_empty_i),
    .rx_pe_i         (rx_pe_i),
    .rx_fe_i         (rx_fe_i),
    .rx_bi_i         (rx_bi_i),
    .overrun_error_i (overrun_error_i),
    .tx_empty_i      (tx_empty_i),
    .tx_sr_empty_i   (tx_sr_empty_i),
    .read_lsr        (read_lsr),
    .lsr             (lsr)
  );

  uart_modem_status u_modem_status (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cts_ni   (cts_ni),
    .dsr_ni   (dsr_ni),
    .dcd_ni   (dcd_ni),
    .ri_ni    (ri_ni),
    .mcr      (mcr),
    .read_msr (read_msr),
    .msr      (msr)
  );

  uart_baud_gen u_baud_gen (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dl        (dl),
    .dl_load   (dl_load),
    .baudout_o (baudout_o)
  );

endmodule

// ==== verification/uart_regs_assert.sv ====
`timescale 1ns/10ps

module uart_regs_assert (
  input logic                           clk_i,
  input logic                           rst_ni,
  input uart_regs_pkg::ier_t            ier,
  input uart_regs_pkg::lsr_t            lsr,
  input uart_regs_pkg::msr_t            msr,
  input uart_regs_pkg::mcr_t            mcr,
  input logic [uart_regs_pkg::DL_W-1:0] dl,
  input logic                           dl_load,
  input logic                           baudout_o,
  input logic                           irq_o,
  input logic                           cts_ni,
  input logic                           ri_ni
);

  int unsigned                    fail_cnt = 0;
  logic                           irq_cond;
  // Cycles since the last baud pulse
  logic [uart_regs_pkg::DL_W-1:0] gap;
  logic [uart_regs_pkg::DL_W-1:0] dl_q;
  // Set once a pulse was seen with a settled divisor
  logic                           armed;

  assign irq_cond = (ier.edssi & (msr.ddcd | msr.teri | msr.ddsr | msr.dcts)) |
                    (ier.elsi & (lsr.oe | lsr.pe | lsr.fe | lsr.bi)) |
                    (ier.etbei & lsr.thre) |
                    (ier.erbi & lsr.dr);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      gap   <= '0;
      dl_q  <= '0;
      armed <= 1'b0;
    end
    else
    begin
      dl_q <= dl;
      gap  <= baudout_o ? 16'd1 : gap + 16'd1;
      if (dl_load || dl != dl_q)
        armed <= 1'b0;
      else if (baudout_o)
        armed <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt
  ////////////////////////////////////////////////////////////////////////////

  irq_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_o == $past(irq_cond))
  else
  begin
    fail_cnt++;
    $error("irq_o does not follow the enabled conditions");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Baud generator
  ////////////////////////////////////////////////////////////////////////////

  // Exactly one pulse per divisor period
  baud_period: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (armed && dl == dl_q && dl != '0) |-> (baudout_o == (gap == dl)))
  else
  begin
    fail_cnt++;
    $error("baudout_o pulse spacing differs from the divisor");
  end

  baud_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dl == '0 && $past(dl) == '0) |-> !baudout_o)
  else
  begin
    fail_cnt++;
    $error("baudout_o pulses with a zero divisor");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Modem
  ////////////////////////////////////////////////////////////////////////////

  // Loopback source mapping
  loop_map: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(mcr.loop) |->
      {msr.dcd, msr.ri, msr.dsr, msr.cts} == $past({mcr.out2, mcr.out1, mcr.dtr, mcr.rts}))
  else
  begin
    fail_cnt++;
    $error("loopback status bits do not match the MCR");
  end

  cts_delta: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cts_ni != $past(cts_ni)) |=> msr.dcts)
  else
  begin
    fail_cnt++;
    $error("dcts not set after a cts pin change");
  end

  // Trailing edge of ring
  ri_delta: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ri_ni && !$past(ri_ni)) |=> msr.teri)
  else
  begin
    fail_cnt++;
    $error("teri not set after the ring pin went high");
  end

endmodule

bind uart_regs_top uart_regs_assert u_assert (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .ier       (u_csr_file.ier),
  .lsr       (lsr),
  .msr       (msr),
  .mcr       (mcr),
  .dl        (dl),
  .dl_load   (dl_load),
  .baudout_o (baudout_o),
  .irq_o     (irq_o),
  .cts_ni    (cts_ni),
  .ri_ni     (ri_ni)
);

// ==== verification/tb_uart_regs.sv ====
`timescale 1ns/10ps

module tb_uart_regs;

  localparam logic [15:0] DL_INIT    = 16'h0123;
  // Well above the length of the whole sequence
  localparam int          MAX_CYCLES = 4000;

  logic       clk_i;
  logic       rst_ni;
  logic [2:0] adr_i;
  logic [7:0] d_i;
  logic       re_i;
  logic       we_i;
  logic [7:0] q_o;
  logic [7:0] rx_data_i;
  logic       rx_empty_i;
  logic       rx_pe_i;
  logic       rx_fe_i;
  logic       rx_bi_i;
  logic       overrun_error_i;
  logic       tx_empty_i;
  logic       tx_sr_empty_i;
  logic       tx_push_o;
  logic       rx_pop_o;
  logic       cts_ni;
  logic       dsr_ni;
  logic       dcd_ni;
  logic       ri_ni;
  logic       rts_no;
  logic       dtr_no;
  logic       out1_no;
  logic       out2_no;
  logic       irq_o;
  logic       baudout_o;

  integer     seed;
  integer     r;
  int         cycle_cnt = 0;
  // Model of LCR dlab
  logic       dlab;
  // Pin levels {dcd, ri, dsr, cts}
  logic [3:0] pins;
  // {rx_empty, tx_empty, tx_sr_empty}
  logic [2:0] lvl;
  // Last MCR value written in the modem loop
  logic [7:0] mcr_val;

  uart_regs_top #(
    .DL_RESET_VALUE (DL_INIT)
  ) DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .adr_i           (adr_i),
    .d_i             (d_i),
    .re_i            (re_i),
    .we_i            (we_i),
    .q_o             (q_o),
    .rx_data_i       (rx_data_i),
    .rx_empty_i      (rx_empty_i),
    .rx_pe_i         (rx_pe_i),
    .rx_fe_i         (rx_fe_i),
    .rx_bi_i         (rx_bi_i),
    .overrun_error_i (overrun_error_i),
    .tx_empty_i      (tx_empty_i),
    .tx_sr_empty_i   (tx_sr_empty_i),
    .tx_push_o       (tx_push_o),
    .rx_pop_o        (rx_pop_o),
    .cts_ni          (cts_ni),
    .dsr_ni          (dsr_ni),
    .dcd_ni          (dcd_ni),
    .ri_ni           (ri_ni),
    .rts_no          (rts_no),
    .dtr_no          (dtr_no),
    .out1_no         (out1_no),
    .out2_no         (out2_no),
    .irq_o           (irq_o),
    .baudout_o       (baudout_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [15:0] act, input logic [15:0] exp);
    if (act !== exp)
    begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Strobes checked mid-cycle, dlab tracked from LCR writes
  task automatic write_reg(input logic [2:0] adr, input logic [7:0] data);
    @(posedge clk_i);
    adr_i <= adr;
    d_i   <= data;
    we_i  <= 1'b1;
    @(negedge clk_i);
    compare("tx_push_o", tx_push_o, (adr == 3'd0) && !dlab);
    compare("rx_pop_o", rx_pop_o, 1'b0);
    @(posedge clk_i);
    we_i <= 1'b0;
    if (adr == uart_regs_pkg::LCR_ADR)
      dlab = data[7];
  endtask

  // q_o valid one cycle after the address
  task automatic read_reg(input logic [2:0] adr, input logic [7:0] exp);
    @(posedge clk_i);
    adr_i <= adr;
    re_i  <= 1'b1;
    @(negedge clk_i);
    compare("rx_pop_o", rx_pop_o, (adr == 3'd0) && !dlab);
    compare("tx_push_o", tx_push_o, 1'b0);
    @(posedge clk_i);
    re_i <= 1'b0;
    @(negedge clk_i);
    compare("q_o", q_o, exp);
  endtask

  // Active-low pins against the MCR value last written
  task automatic check_modem_outs(input logic [7:0] m);
    @(negedge clk_i);
    compare("{out2_no, out1_no, rts_no, dtr_no}",
            {out2_no, out1_no, rts_no, dtr_no},
            {~m[3], ~m[2], ~m[1], ~m[0]});
  endtask

  function automatic logic [7:0] lsr_levels(input logic [2:0] l);
    return {1'b0, l[1] & l[0], l[1], 4'b0000, ~l[2]};
  endfunction

  task automatic set_levels(input logic [2:0] l);
    @(posedge clk_i);
    rx_empty_i    <= l[2];
    tx_empty_i    <= l[1];
    tx_sr_empty_i <= l[0];
    repeat (2) @(posedge clk_i);
  endtask

  // One-cycle pulse, 0 overrun, 1 parity, 2 framing, 3 break
  task automatic pulse_error(input logic [1:0] k);
    @(posedge clk_i);
    case (k)
      2'd0:    overrun_error_i <= 1'b1;
      2'd1:    rx_pe_i <= 1'b1;
      2'd2:    rx_fe_i <= 1'b1;
      default: rx_bi_i <= 1'b1;
    endcase
    @(posedge clk_i);
    {rx_bi_i, rx_fe_i, rx_pe_i, overrun_error_i} <= 4'b0000;
    repeat (2) @(posedge clk_i);
  endtask

  // New pin levels, then two MSR reads
  task automatic modem_step(input logic [3:0] np, input logic [7:0] m);
    logic [3:0] delta;
    logic [3:0] status;
    delta = {np[3] ^ pins[3], np[2] & ~pins[2], np[1] ^ pins[1], np[0] ^ pins[0]};
    // Loopback takes status from out2, out1, dtr and rts
    status = m[4] ? {m[3], m[2], m[0], m[1]} : ~np;
    @(posedge clk_i);
    {dcd_ni, ri_ni, dsr_ni, cts_ni} <= np;
    repeat (2) @(posedge clk_i);
    pins = np;
    read_reg(uart_regs_pkg::MSR_ADR, {status, delta});
    read_reg(uart_regs_pkg::MSR_ADR, {status, 4'h0});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Timeout and assertion watch
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout, the test sequence did not finish in time");
      $display("=== FAIL ===");
      $fatal(1, "Timeout");
    end
  end

  always @(negedge clk_i)
  begin
    if (DUT.u_assert.fail_cnt != 0)
    begin
      $display("A bound assertion on the DUT failed");
      $display("=== FAIL ===");
      $fatal(1, "Assertion failure");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed = 75488;
    dlab = 1'b0;
    pins = 4'hF;
    lvl  = 3'b111;
    mcr_val = 8'h00;
    rst_ni = 1'b0;
    adr_i = '0;
    d_i = '0;
    re_i = 1'b0;
    we_i = 1'b0;
    rx_data_i = '0;
    {rx_empty_i, tx_empty_i, tx_sr_empty_i} = lvl;
    {rx_pe_i, rx_fe_i, rx_bi_i, overrun_error_i} = 4'b0000;
    {dcd_ni, ri_ni, dsr_ni, cts_ni} = pins;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values
    @(posedge clk_i);
    r = $random(seed);
    rx_data_i <= r[7:0];
    read_reg(uart_regs_pkg::RBR_ADR, r[7:0]);
    read_reg(uart_regs_pkg::IER_ADR, 8'h00);
    read_reg(uart_regs_pkg::IIR_ADR, 8'h00);
    read_reg(uart_regs_pkg::LCR_ADR, 8'h00);
    read_reg(uart_regs_pkg::MCR_ADR, 8'h00);
    read_reg(uart_regs_pkg::LSR_ADR, 8'h60);
    read_reg(uart_regs_pkg::MSR_ADR, 8'h00);
    read_reg(uart_regs_pkg::SCR_ADR, 8'h00);
    check_modem_outs(8'h00);

    // Divisor latch behind dlab
    write_reg(uart_regs_pkg::LCR_ADR, 8'h80);
    read_reg(uart_regs_pkg::DLL_ADR, DL_INIT[7:0]);
    read_reg(uart_regs_pkg::DLM_ADR, DL_INIT[15:8]);
    write_reg(uart_regs_pkg::DLL_ADR, 8'h5A);
    write_reg(uart_regs_pkg::DLM_ADR, 8'h3C);
    read_reg(uart_regs_pkg::DLL_ADR, 8'h5A);
    read_reg(uart_regs_pkg::DLM_ADR, 8'h3C);
    write_reg(uart_regs_pkg::LCR_ADR, 8'h1B);
    read_reg(uart_regs_pkg::IER_ADR, 8'h00);
    read_reg(uart_regs_pkg::LCR_ADR, 8'h1B);

    // Plain registers, reserved bits masked
    write_reg(uart_regs_pkg::IER_ADR, 8'hF5);
    read_reg(uart_regs_pkg::IER_ADR, 8'h05);
    write_reg(uart_regs_pkg::MCR_ADR, 8'hFF);
    check_modem_outs(8'hFF);
    read_reg(uart_regs_pkg::MCR_ADR, 8'h1F);
    write_reg(uart_regs_pkg::SCR_ADR, 8'hC3);
    read_reg(uart_regs_pkg::SCR_ADR, 8'hC3);
    write_reg(uart_regs_pkg::THR_ADR, 8'h55);
    @(posedge clk_i);
    r = $random(seed);
    rx_data_i <= r[7:0];
    read_reg(uart_regs_pkg::RBR_ADR, r[7:0]);

    // Baud generator, divisors 3, 7 and 0
    write_reg(uart_regs_pkg::LCR_ADR, 8'h80);
    write_reg(uart_regs_pkg::DLM_ADR, 8'h00);
    write_reg(uart_regs_pkg::DLL_ADR, 8'h03);
    repeat (30) @(posedge clk_i);
    write_reg(uart_regs_pkg::DLL_ADR, 8'h07);
    repeat (60) @(posedge clk_i);
    write_reg(uart_regs_pkg::DLL_ADR, 8'h00);
    repeat (20) @(posedge clk_i);
    write_reg(uart_regs_pkg::LCR_ADR, 8'h03);

    // Line status, all interrupts enabled
    write_reg(uart_regs_pkg::IER_ADR, 8'h0F);
    for (int i = 0; i < 4; i++)
    begin
      r = $random(seed);
      lvl = r[2:0];
      set_levels(lvl);
      read_reg(uart_regs_pkg::LSR_ADR, lsr_levels(lvl));
    end
    for (int i = 0; i < 4; i++)
    begin
      r = $random(seed);
      pulse_error(r[1:0]);
      read_reg(uart_regs_pkg::LSR_ADR, lsr_levels(lvl) | (8'h02 << r[1:0]));
      read_reg(uart_regs_pkg::LSR_ADR, lsr_levels(lvl));
    end

    // Modem pins and controls, loopback on every other step
    for (int i = 0; i < 6; i++)
    begin
      r = $random(seed);
      mcr_val = {3'h0, i[0], r[7:4]};
      write_reg(uart_regs_pkg::MCR_ADR, mcr_val);
      check_modem_outs(mcr_val);
      modem_step(r[3:0], mcr_val);
    end

    // Interrupt off again
    write_reg(uart_regs_pkg::IER_ADR, 8'h00);
    repeat (5) @(posedge clk_i);
    if (DUT.u_assert.fail_cnt != 0)
    begin
      $display("=== FAIL ===");
      $fatal(1, "Assertion failure");
    end
    else
    begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== project.f ====
verilog/uart_regs_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_line_status.sv
verilog/uart_modem_status.sv
verilog/uart_csr_file.sv
verilog/uart_regs_top.sv
verification/uart_regs_assert.sv
verification/tb_uart_regs.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_uart_regs -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_uart_regs +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
